//--- src/dbg_cmd_pkg.sv
// Debug command and result types

package dbg_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and control register
  ////////////////////////////////////////////////////////////////////////////

  // Command opcode, unknown codes act as NOP
  typedef enum logic [3:0] {
    NOP     = 4'd0,
    CTRL_WR = 4'd1,
    CTRL_RD = 4'd2,
    SPR_WR  = 4'd3,
    SPR_RD  = 4'd4
  } dbg_op_e;

  // Width of the control register
  localparam int CTRL_LEN = 2;

  // Bit 1 resets the CPU, bit 0 stalls it
  typedef struct packed {
    logic cpu_reset;
    logic stall;
  } ctrl_reg_t;

  ////////////////////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////////////////////

  // Payload as seen by a control write
  typedef struct packed {
    logic [47-CTRL_LEN:0] rsvd;
    ctrl_reg_t            ctrl;
  } ctrl_view_t;

  // Payload as seen by an SPR access
  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] data;
  } spr_view_t;

  // Same 48 bits, decoded by opcode
  typedef union packed {
    ctrl_view_t ctrl;
    spr_view_t  spr;
  } dbg_payload_u;

  // Opcode sits in the low bits, so it is shifted in first
  typedef struct packed {
    dbg_payload_u payload;
    dbg_op_e      op;
  } dbg_cmd_t;

  // Captured status, shifted out LSB first
  typedef struct packed {
    logic [31:0] spr_rdata;
    logic        spr_err;
    logic        spr_busy;
    ctrl_reg_t   ctrl;
  } dbg_result_t;

  // SPR request handed to the CPU-side access block
  typedef struct packed {
    logic        we;
    logic [15:0] addr;
    logic [31:0] data;
  } spr_req_t;

endpackage

//--- src/dbg_bus_pkg.sv
// SPR bus AXI4-Lite types

package dbg_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // Channels
  ////////////////////////////////////////////////////////////////////////////

  // Master to slave, write and read address/data plus response ready
  typedef struct packed {
    logic        awvalid;
    logic [15:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [15:0] araddr;
    logic        rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

//--- src/dbg_cmd_shift.sv
// JTAG command shift register

module dbg_cmd_shift (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   tdi_i,
  input  logic                   capture_i,
  input  logic                   shift_i,
  input  logic                   update_i,
  input  dbg_cmd_pkg::ctrl_reg_t ctrl_reg_i,
  input  logic                   spr_busy_i,
  input  logic                   spr_err_i,
  input  logic [31:0]            spr_rdata_i,
  output logic                   tdo_o,
  output logic                   ctrl_we_o,
  output dbg_cmd_pkg::ctrl_reg_t ctrl_data_o,
  output logic                   spr_start_o,
  output dbg_cmd_pkg::spr_req_t  spr_req_o
);

  localparam int CMD_W = $bits(dbg_cmd_pkg::dbg_cmd_t);
  localparam int RES_W = $bits(dbg_cmd_pkg::dbg_result_t);

  logic [CMD_W-1:0]         shift_q;
  dbg_cmd_pkg::dbg_cmd_t    cmd;
  dbg_cmd_pkg::dbg_result_t result;
  logic                     ctrl_we_d;
  logic                     spr_start_d;
  logic                     spr_we_d;

  ////////////////////////////////////////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////////////////////////////////////////

  // Status word seen by the host on capture
  always_comb begin
    result.spr_rdata = spr_rdata_i;
    result.spr_err   = spr_err_i;
    result.spr_busy  = spr_busy_i;
    result.ctrl      = ctrl_reg_i;
  end

  // Capture parks the result in the low bits
  // Shift enters at the top, so bit 0 is always next out
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      shift_q <= '0;
    end else if (capture_i) begin
      shift_q <= {{(CMD_W-RES_W){1'b0}}, result};
    end else if (shift_i) begin
      shift_q <= {tdi_i, shift_q[CMD_W-1:1]};
    end
  end

  assign tdo_o = shift_q[0];

  ////////////////////////////////////////////////////////////////////////////
  // Update decode
  ////////////////////////////////////////////////////////////////////////////

  assign cmd = shift_q;

  // CTRL_RD and NOP need no strobe, the host reads via capture
  always_comb begin
    ctrl_we_d   = 1'b0;
    spr_start_d = 1'b0;
    spr_we_d    = 1'b0;
    case (cmd.op)
      dbg_cmd_pkg::CTRL_WR: begin
        ctrl_we_d = 1'b1;
      end
      dbg_cmd_pkg::SPR_WR: begin
        // Dropped while an access is still in flight
        spr_start_d = ~spr_busy_i;
        spr_we_d    = 1'b1;
      end
      dbg_cmd_pkg::SPR_RD: begin
        spr_start_d = ~spr_busy_i;
      end
      default: begin
        ctrl_we_d = 1'b0;
      end
    endcase
  end

  // One tck strobe per update
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      ctrl_we_o   <= 1'b0;
      spr_start_o <= 1'b0;
    end else begin
      ctrl_we_o   <= update_i & ctrl_we_d;
      spr_start_o <= update_i & spr_start_d;
    end
  end

  // Payload through the matching union view
  always_ff @(posedge tck_i) begin
    if (update_i) begin
      ctrl_data_o    <= cmd.payload.ctrl.ctrl;
      spr_req_o.we   <= spr_we_d;
      spr_req_o.addr <= cmd.payload.spr.addr;
      spr_req_o.data <= cmd.payload.spr.data;
    end
  end

endmodule

//--- src/dbg_status_reg.sv
// CPU stall and reset control

module dbg_status_reg (
  input  dbg_cmd_pkg::ctrl_reg_t data_i,
  input  logic                   we_i,
  input  logic                   tck_i,
  input  logic                   bp_i,
  input  logic                   rst_i,
  input  logic                   cpu_clk_i,
  output logic                   cpu_stall_o,
  output logic                   cpu_rst_o,
  output dbg_cmd_pkg::ctrl_reg_t ctrl_reg_o
);

  // Breakpoint latch and its copy in tck
  logic stall_bp_q;
  logic stall_bp_meta_q;
  logic stall_bp_tck_q;

  // Host stall and its copy in cpu_clk
  logic stall_q;
  logic stall_meta_q;
  logic stall_cpu_q;

  // Host reset and its copy in cpu_clk
  logic reset_q;
  logic reset_meta_q;

  ////////////////////////////////////////////////////////////////////////////
  // CPU clock domain
  ////////////////////////////////////////////////////////////////////////////

  // Breakpoint only sets the latch
  // Cleared once the host stall bit is seen, so the host always sees it
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      stall_bp_q <= 1'b0;
    end else if (bp_i) begin
      stall_bp_q <= 1'b1;
    end else if (stall_cpu_q) begin
      stall_bp_q <= 1'b0;
    end
  end

  // Two-flop sync of host stall and reset
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      stall_meta_q <= 1'b0;
      stall_cpu_q  <= 1'b0;
      reset_meta_q <= 1'b0;
      cpu_rst_o    <= 1'b0;
    end else begin
      stall_meta_q <= stall_q;
      stall_cpu_q  <= stall_meta_q;
      reset_meta_q <= reset_q;
      cpu_rst_o    <= reset_meta_q;
    end
  end

  // bp_i stalls at once, latch holds it, host may add its own
  assign cpu_stall_o = bp_i | stall_bp_q | stall_cpu_q;

  ////////////////////////////////////////////////////////////////////////////
  // TCK domain
  ////////////////////////////////////////////////////////////////////////////

  // Breakpoint latch into tck
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_bp_meta_q <= 1'b0;
      stall_bp_tck_q  <= 1'b0;
    end else begin
      stall_bp_meta_q <= stall_bp_q;
      stall_bp_tck_q  <= stall_bp_meta_q;
    end
  end

  // Stall set by breakpoint or host, cleared only by host
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_q <= 1'b0;
    end else if (stall_bp_tck_q) begin
      stall_q <= 1'b1;
    end else if (we_i) begin
      stall_q <= data_i.stall;
    end
  end

  // CPU reset is host-written only
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      reset_q <= 1'b0;
    end else if (we_i) begin
      reset_q <= data_i.cpu_reset;
    end
  end

  // Read back for capture
  always_comb begin
    ctrl_reg_o.cpu_reset = reset_q;
    ctrl_reg_o.stall     = stall_q;
  end

endmodule

//--- src/dbg_spr_access.sv
// SPR access across clock domains

module dbg_spr_access #(
  parameter int SPR_AW = 16
) (
  input  logic                   tck_i,
  input  logic                   cpu_clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  dbg_cmd_pkg::spr_req_t  req_i,
  input  logic                   cpu_stall_i,
  input  dbg_bus_pkg::axil_rsp_t spr_rsp_i,
  output logic                   busy_o,
  output logic                   err_o,
  output logic [31:0]            rdata_o,
  output dbg_bus_pkg::axil_req_t spr_req_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_RESP
  } state_e;

  // Request held in tck, read by the CPU side during the transfer
  logic              we_q;
  logic [SPR_AW-1:0] addr_q;
  logic [31:0]       data_q;

  // Toggle handshake
  logic req_tgl_q;
  logic req_meta_q;
  logic req_sync_q;
  logic req_seen_q;
  logic req_edge;
  logic done_tgl_q;
  logic done_meta_q;
  logic done_sync_q;
  logic done_seen_q;
  logic done_edge;

  // AXI4-Lite master state
  state_e      state_q;
  logic        awvalid_q;
  logic        wvalid_q;
  logic        bready_q;
  logic        arvalid_q;
  logic        rready_q;
  logic        aw_done;
  logic        w_done;
  logic        err_cpu_q;
  logic [31:0] rdata_cpu_q;

  ////////////////////////////////////////////////////////////////////////////
  // TCK side
  ////////////////////////////////////////////////////////////////////////////

  // Latch request, stable until busy drops
  always_ff @(posedge tck_i) begin
    if (start_i) begin
      we_q   <= req_i.we;
      addr_q <= req_i.addr[SPR_AW-1:0];
      data_q <= req_i.data;
    end
  end

  // Done toggle back into tck
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      done_meta_q <= 1'b0;
      done_sync_q <= 1'b0;
      done_seen_q <= 1'b0;
    end else begin
      done_meta_q <= done_tgl_q;
      done_sync_q <= done_meta_q;
      done_seen_q <= done_sync_q;
    end
  end

  assign done_edge = done_sync_q ^ done_seen_q;

  // Busy from start to returned done
  // Result copied once the CPU side has settled
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      req_tgl_q <= 1'b0;
      busy_o    <= 1'b0;
      err_o     <= 1'b0;
      rdata_o   <= '0;
    end else if (start_i) begin
      req_tgl_q <= ~req_tgl_q;
      busy_o    <= 1'b1;
    end else if (done_edge) begin
      busy_o  <= 1'b0;
      err_o   <= err_cpu_q;
      rdata_o <= rdata_cpu_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////////////////////////////////////////

  // Request toggle into cpu_clk
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      req_meta_q <= 1'b0;
      req_sync_q <= 1'b0;
      req_seen_q <= 1'b0;
    end else begin
      req_meta_q <= req_tgl_q;
      req_sync_q <= req_meta_q;
      req_seen_q <= req_sync_q;
    end
  end

  assign req_edge = req_sync_q ^ req_seen_q;

  // Channel finished this cycle or earlier
  assign aw_done = ~awvalid_q | spr_rsp_i.awready;
  assign w_done  = ~wvalid_q | spr_rsp_i.wready;

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      awvalid_q  <= 1'b0;
      wvalid_q   <= 1'b0;
      bready_q   <= 1'b0;
      arvalid_q  <= 1'b0;
      rready_q   <= 1'b0;
      err_cpu_q  <= 1'b0;
      done_tgl_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_edge) begin
            if (!cpu_stall_i) begin
              // Running CPU, refuse without touching the bus
              err_cpu_q  <= 1'b1;
              done_tgl_q <= ~done_tgl_q;
            end else begin
              // AW and W go out together
              awvalid_q <= we_q;
              wvalid_q  <= we_q;
              arvalid_q <= ~we_q;
              state_q   <= ST_ADDR;
            end
          end
        end
        ST_ADDR: begin
          if (we_q) begin
            if (spr_rsp_i.awready) begin
              awvalid_q <= 1'b0;
            end
            if (spr_rsp_i.wready) begin
              wvalid_q <= 1'b0;
            end
            if (aw_done && w_done) begin
              bready_q <= 1'b1;
              state_q  <= ST_RESP;
            end
          end else if (spr_rsp_i.arready) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b1;
            state_q   <= ST_RESP;
          end
        end
        ST_RESP: begin
          // Wait as long as the slave needs
          if (we_q && spr_rsp_i.bvalid) begin
            bready_q   <= 1'b0;
            err_cpu_q  <= spr_rsp_i.bresp != dbg_bus_pkg::RESP_OKAY;
            done_tgl_q <= ~done_tgl_q;
            state_q    <= ST_IDLE;
          end else if (!we_q && spr_rsp_i.rvalid) begin
            rready_q   <= 1'b0;
            err_cpu_q  <= spr_rsp_i.rresp != dbg_bus_pkg::RESP_OKAY;
            done_tgl_q <= ~done_tgl_q;
            state_q    <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Read data kept until the next read
  always_ff @(posedge cpu_clk_i) begin
    if (state_q == ST_RESP && !we_q && spr_rsp_i.rvalid) begin
      rdata_cpu_q <= spr_rsp_i.rdata;
    end
  end

  // Bus outputs from the registered handshake bits
  always_comb begin
    spr_req_o.awvalid = awvalid_q;
    spr_req_o.awaddr  = 16'(addr_q);
    spr_req_o.wvalid  = wvalid_q;
    spr_req_o.wdata   = data_q;
    spr_req_o.wstrb   = 4'hf;
    spr_req_o.bready  = bready_q;
    spr_req_o.arvalid = arvalid_q;
    spr_req_o.araddr  = 16'(addr_q);
    spr_req_o.rready  = rready_q;
  end

endmodule

//--- src/dbg_cpu_top.sv
// Debug unit CPU control top

module dbg_cpu_top #(
  parameter int SPR_AW = 16
) (
  input  logic                   cpu_clk_i,
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   tdi_i,
  input  logic                   capture_i,
  input  logic                   shift_i,
  input  logic                   update_i,
  input  logic                   bp_i,
  input  dbg_bus_pkg::axil_rsp_t spr_rsp_i,
  output logic                   tdo_o,
  output logic                   cpu_stall_o,
  output logic                   cpu_rst_o,
  output dbg_bus_pkg::axil_req_t spr_req_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////////////////////

  // Control register path
  logic                   ctrl_we;
  dbg_cmd_pkg::ctrl_reg_t ctrl_data;
  dbg_cmd_pkg::ctrl_reg_t ctrl_reg;

  // SPR path
  logic                   spr_start;
  dbg_cmd_pkg::spr_req_t  spr_req;
  logic                   spr_busy;
  logic                   spr_err;
  logic [31:0]            spr_rdata;

  // Host command decode, tck only
  dbg_cmd_shift u_cmd_shift (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .tdi_i       (tdi_i),
    .capture_i   (capture_i),
    .shift_i     (shift_i),
    .update_i    (update_i),
    .ctrl_reg_i  (ctrl_reg),
    .spr_busy_i  (spr_busy),
    .spr_err_i   (spr_err),
    .spr_rdata_i (spr_rdata),
    .tdo_o       (tdo_o),
    .ctrl_we_o   (ctrl_we),
    .ctrl_data_o (ctrl_data),
    .spr_start_o (spr_start),
    .spr_req_o   (spr_req)
  );

  // Stall and reset toward the CPU
  dbg_status_reg u_status_reg (
    .data_i      (ctrl_data),
    .we_i        (ctrl_we),
    .tck_i       (tck_i),
    .bp_i        (bp_i),
    .rst_i       (rst_i),
    .cpu_clk_i   (cpu_clk_i),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o),
    .ctrl_reg_o  (ctrl_reg)
  );

  // SPR bus master, only active while the CPU is stalled
  dbg_spr_access #(
    .SPR_AW (SPR_AW)
  ) u_spr_access (
    .tck_i       (tck_i),
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .start_i     (spr_start),
    .req_i       (spr_req),
    .cpu_stall_i (cpu_stall_o),
    .spr_rsp_i   (spr_rsp_i),
    .busy_o      (spr_busy),
    .err_o       (spr_err),
    .rdata_o     (spr_rdata),
    .spr_req_o   (spr_req_o)
  );

endmodule

//--- tb/tb_dbg_cpu_top.sv
// Debug unit CPU control testbench

module tb_dbg_cpu_top;

  timeunit 1ns;
  timeprecision 1ps;

  // About 20 command scans of 54 tck and 26 result scans of 38 tck
  // Near 7300 cpu cycles at 3.5 cpu cycles per tck, limit leaves margin
  localparam int TIMEOUT_CYCLES = 12000;
  localparam int MODEL_WORDS    = 16;

  logic                   cpu_clk_i;
  logic                   tck_i;
  logic                   rst_i;
  logic                   tdi_i;
  logic                   capture_i;
  logic                   shift_i;
  logic                   update_i;
  logic                   bp_i;
  dbg_bus_pkg::axil_rsp_t spr_rsp_i;
  logic                   tdo_o;
  logic                   cpu_stall_o;
  logic                   cpu_rst_o;
  dbg_bus_pkg::axil_req_t spr_req_o;

  // Test state
  int                     err_cnt;
  int                     cycle_cnt;
  int                     xfer_cnt;
  int                     base_delay;
  int                     delay_bits;
  logic [15:0]            lfsr_q;
  logic [31:0]            model_mem [MODEL_WORDS];
  dbg_bus_pkg::axil_req_t valid_hist;

  dbg_cpu_top #(
    .SPR_AW (16)
  ) u_dbg_cpu_top (
    .cpu_clk_i   (cpu_clk_i),
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .tdi_i       (tdi_i),
    .capture_i   (capture_i),
    .shift_i     (shift_i),
    .update_i    (update_i),
    .bp_i        (bp_i),
    .spr_rsp_i   (spr_rsp_i),
    .tdo_o       (tdo_o),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o),
    .spr_req_o   (spr_req_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clocks and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cpu_clk_i = 1'b0;
    forever #10 cpu_clk_i = ~cpu_clk_i;
  end

  // Slower and unrelated to cpu_clk_i
  initial begin
    tck_i = 1'b0;
    forever #35 tck_i = ~tck_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge cpu_clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cpu cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // Every valid the master has raised since the last clear
  always @(negedge cpu_clk_i) begin
    valid_hist = valid_hist | spr_req_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and SPR slave model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic wait_slave_delay();
    int n;
    n = base_delay + int'(rand_bits(delay_bits));
    repeat (n) @(negedge cpu_clk_i);
  endtask

  // 16 words with SLVERR above them
  // Handshakes change on falling edges only
  initial begin : spr_slave
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    spr_rsp_i = '0;
    forever begin
      @(negedge cpu_clk_i);
      if (spr_req_o.awvalid && spr_req_o.wvalid) begin
        addr = spr_req_o.awaddr;
        data = spr_req_o.wdata;
        strb = spr_req_o.wstrb;
        wait_slave_delay();
        spr_rsp_i.awready = 1'b1;
        spr_rsp_i.wready  = 1'b1;
        @(negedge cpu_clk_i);
        spr_rsp_i.awready = 1'b0;
        spr_rsp_i.wready  = 1'b0;
        while (!spr_req_o.bready) @(negedge cpu_clk_i);
        wait_slave_delay();
        if (addr < 16'd16) begin
          // Only strobed byte lanes are written
          for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
              model_mem[addr[3:0]][8*b +: 8] = data[8*b +: 8];
            end
          end
          spr_rsp_i.bresp = dbg_bus_pkg::RESP_OKAY;
        end else begin
          spr_rsp_i.bresp = dbg_bus_pkg::RESP_SLVERR;
        end
        spr_rsp_i.bvalid = 1'b1;
        @(negedge cpu_clk_i);
        spr_rsp_i.bvalid = 1'b0;
        xfer_cnt++;
      end else if (spr_req_o.arvalid) begin
        addr = spr_req_o.araddr;
        wait_slave_delay();
        spr_rsp_i.arready = 1'b1;
        @(negedge cpu_clk_i);
        spr_rsp_i.arready = 1'b0;
        while (!spr_req_o.rready) @(negedge cpu_clk_i);
        wait_slave_delay();
        if (addr < 16'd16) begin
          spr_rsp_i.rdata = model_mem[addr[3:0]];
          spr_rsp_i.rresp = dbg_bus_pkg::RESP_OKAY;
        end else begin
          spr_rsp_i.rdata = 32'hdead_beef;
          spr_rsp_i.rresp = dbg_bus_pkg::RESP_SLVERR;
        end
        spr_rsp_i.rvalid = 1'b1;
        @(negedge cpu_clk_i);
        spr_rsp_i.rvalid = 1'b0;
        xfer_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_ctrl(input string name, input dbg_cmd_pkg::ctrl_reg_t got,
                            input dbg_cmd_pkg::ctrl_reg_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_result_data(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_axil_idle(input string name, input dbg_bus_pkg::axil_req_t req);
    check_bit({name, ".awvalid"}, req.awvalid, 1'b0);
    check_bit({name, ".wvalid"}, req.wvalid, 1'b0);
    check_bit({name, ".arvalid"}, req.arvalid, 1'b0);
    check_bit({name, ".bready"}, req.bready, 1'b0);
    check_bit({name, ".rready"}, req.rready, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // JTAG scans
  ////////////////////////////////////////////////////////////////////////////

  function automatic dbg_cmd_pkg::dbg_cmd_t ctrl_cmd(input dbg_cmd_pkg::dbg_op_e op,
                                                     input dbg_cmd_pkg::ctrl_reg_t v);
    dbg_cmd_pkg::dbg_cmd_t c;
    c = '0;
    c.op = op;
    c.payload.ctrl.ctrl = v;
    return c;
  endfunction

  function automatic dbg_cmd_pkg::dbg_cmd_t spr_cmd(input dbg_cmd_pkg::dbg_op_e op,
                                                    input logic [15:0] addr,
                                                    input logic [31:0] data);
    dbg_cmd_pkg::dbg_cmd_t c;
    c = '0;
    c.op = op;
    c.payload.spr.addr = addr;
    c.payload.spr.data = data;
    return c;
  endfunction

  // Shift LSB first and pulse update once
  task automatic shift_cmd(input dbg_cmd_pkg::dbg_cmd_t c);
    @(negedge tck_i);
    shift_i = 1'b1;
    for (int i = 0; i < $bits(c); i++) begin
      tdi_i = c[i];
      @(negedge tck_i);
    end
    shift_i  = 1'b0;
    tdi_i    = 1'b0;
    update_i = 1'b1;
    @(negedge tck_i);
    update_i = 1'b0;
  endtask

  task automatic read_result(output dbg_cmd_pkg::dbg_result_t r);
    @(negedge tck_i);
    capture_i = 1'b1;
    @(negedge tck_i);
    capture_i = 1'b0;
    shift_i   = 1'b1;
    for (int i = 0; i < $bits(r); i++) begin
      r[i] = tdo_o;
      @(negedge tck_i);
    end
    shift_i = 1'b0;
  endtask

  // Poll the captured busy bit
  task automatic wait_spr_idle(output dbg_cmd_pkg::dbg_result_t r);
    int tries;
    tries = 0;
    read_result(r);
    while (r.spr_busy && tries < 20) begin
      read_result(r);
      tries++;
    end
    if (r.spr_busy) begin
      $display("SPR access still busy after %0d polls", tries);
      err_cnt++;
    end
  endtask

  // Bound in cpu cycles after the scan ends
  task automatic wait_cpu_outputs(input logic stall_exp, input logic rst_exp,
                                  input int bound);
    int n;
    n = 0;
    while ((cpu_stall_o !== stall_exp || cpu_rst_o !== rst_exp) && n < bound) begin
      @(negedge cpu_clk_i);
      n++;
    end
    check_bit("cpu_stall_o", cpu_stall_o, stall_exp);
    check_bit("cpu_rst_o", cpu_rst_o, rst_exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    dbg_cmd_pkg::dbg_result_t r;
    check_bit("cpu_stall_o", cpu_stall_o, 1'b0);
    check_bit("cpu_rst_o", cpu_rst_o, 1'b0);
    check_axil_idle("spr_req_o", spr_req_o);
    read_result(r);
    check_ctrl("result.ctrl", r.ctrl, 2'b00);
    check_bit("result.spr_busy", r.spr_busy, 1'b0);
  endtask

  task automatic test_host_control();
    dbg_cmd_pkg::dbg_result_t r;
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b01));
    wait_cpu_outputs(1'b1, 1'b0, 10);
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b11));
    wait_cpu_outputs(1'b1, 1'b1, 10);
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_RD, 2'b00));
    read_result(r);
    check_ctrl("result.ctrl", r.ctrl, 2'b11);
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b00));
    wait_cpu_outputs(1'b0, 1'b0, 10);
  endtask

  task automatic test_breakpoint();
    dbg_cmd_pkg::dbg_result_t r;
    @(negedge cpu_clk_i);
    bp_i = 1'b1;
    #1;
    // Combinational path needs no clock
    check_bit("cpu_stall_o", cpu_stall_o, 1'b1);
    @(negedge cpu_clk_i);
    bp_i = 1'b0;
    repeat (5) begin
      @(negedge cpu_clk_i);
      check_bit("cpu_stall_o", cpu_stall_o, 1'b1);
    end
    repeat (4) @(negedge tck_i);
    read_result(r);
    check_ctrl("result.ctrl", r.ctrl, 2'b01);
    check_bit("cpu_stall_o", cpu_stall_o, 1'b1);
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b00));
    wait_cpu_outputs(1'b0, 1'b0, 10);
  endtask

  task automatic test_spr_transfers();
    dbg_cmd_pkg::dbg_result_t r;
    logic [15:0]              addr;
    logic [31:0]              data;
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b01));
    wait_cpu_outputs(1'b1, 1'b0, 10);
    repeat (3) begin
      addr = 16'(rand_bits(4));
      data = rand_bits(32);
      shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_WR, addr, data));
      wait_spr_idle(r);
      check_bit("result.spr_err", r.spr_err, 1'b0);
      check_result_data("model_mem", model_mem[addr[3:0]], data);
      shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_RD, addr, 32'h0));
      wait_spr_idle(r);
      check_bit("result.spr_err", r.spr_err, 1'b0);
      check_result_data("result.spr_rdata", r.spr_rdata, data);
    end
  endtask

  task automatic test_spr_errors();
    dbg_cmd_pkg::dbg_result_t r;
    int                       xfers_before;
    // A running CPU refuses the request without touching the bus
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b00));
    wait_cpu_outputs(1'b0, 1'b0, 10);
    @(posedge cpu_clk_i);
    valid_hist = '0;
    shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_WR, 16'h0003, 32'h1234_5678));
    wait_spr_idle(r);
    check_bit("result.spr_err", r.spr_err, 1'b1);
    check_axil_idle("spr_req_o history", valid_hist);
    // Read above the model's range with the CPU stalled again
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b01));
    wait_cpu_outputs(1'b1, 1'b0, 10);
    xfers_before = xfer_cnt;
    shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_RD, 16'h0040, 32'h0));
    wait_spr_idle(r);
    check_bit("result.spr_err", r.spr_err, 1'b1);
    check_result_data("bus transfers", 32'(xfer_cnt - xfers_before), 32'd1);
  endtask

  task automatic test_back_pressure();
    dbg_cmd_pkg::dbg_result_t r;
    int                       xfers_before;
    logic [31:0]              data;
    logic [31:0]              other;
    data  = rand_bits(32);
    other = ~data;
    shift_cmd(ctrl_cmd(dbg_cmd_pkg::CTRL_WR, 2'b01));
    wait_cpu_outputs(1'b1, 1'b0, 10);
    shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_WR, 16'h0005, data));
    wait_spr_idle(r);
    check_bit("result.spr_err", r.spr_err, 1'b0);
    // Each handshake now waits 200 to 215 cpu cycles
    base_delay   = 200;
    delay_bits   = 4;
    xfers_before = xfer_cnt;
    shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_RD, 16'h0005, 32'h0));
    shift_cmd(spr_cmd(dbg_cmd_pkg::SPR_WR, 16'h0006, other));
    read_result(r);
    check_bit("result.spr_busy", r.spr_busy, 1'b1);
    check_result_data("bus transfers while busy", 32'(xfer_cnt - xfers_before), 32'd0);
    wait_spr_idle(r);
    check_bit("result.spr_err", r.spr_err, 1'b0);
    check_result_data("result.spr_rdata", r.spr_rdata, data);
    check_result_data("bus transfers", 32'(xfer_cnt - xfers_before), 32'd1);
    if (model_mem[6] === other) begin
      $display("Dropped SPR write reached the slave at address 6");
      err_cnt++;
    end
    base_delay = 0;
    delay_bits = 2;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_i      = 1'b1;
    tdi_i      = 1'b0;
    capture_i  = 1'b0;
    shift_i    = 1'b0;
    update_i   = 1'b0;
    bp_i       = 1'b0;
    err_cnt    = 0;
    xfer_cnt   = 0;
    base_delay = 0;
    delay_bits = 2;
    lfsr_q     = 16'd1020;
    valid_hist = '0;
    for (int i = 0; i < MODEL_WORDS; i++) begin
      model_mem[i] = 32'h5a00_0000 | (i * 32'h0001_0101);
    end
    repeat (10) @(negedge cpu_clk_i);
    rst_i = 1'b0;
    repeat (3) @(negedge tck_i);

    test_reset_state();
    test_host_control();
    test_breakpoint();
    test_spr_transfers();
    test_spr_errors();
    test_back_pressure();

    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
src/dbg_cmd_pkg.sv
src/dbg_bus_pkg.sv
src/dbg_cmd_shift.sv
src/dbg_status_reg.sv
src/dbg_spr_access.sv
src/dbg_cpu_top.sv
tb/tb_dbg_cpu_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_dbg_cpu_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dbg_cpu_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
